/* hdl/core_isa_pkg.sv */
/*
 * Instruction set: opcodes, instruction word layout,
 * decode flags and register file sizes
 */
`default_nettype none

package core_isa_pkg;

  localparam int reg_addr_width_gp = 5;
  localparam int reg_els_gp = 32;

  // Codes not listed here decode as a no-op
  typedef enum logic [4:0] {
    op_add  = 5'd0,
    op_sub  = 5'd1,
    op_and  = 5'd2,
    op_or   = 5'd3,
    op_xor  = 5'd4,
    op_sll  = 5'd5,
    op_srl  = 5'd6,
    op_addi = 5'd7,
    op_mul  = 5'd8
  } opcode_e;

  typedef struct packed {
    logic [4:0] opcode;
    logic [reg_addr_width_gp-1:0] rd;
    logic [reg_addr_width_gp-1:0] rs1;
    logic [reg_addr_width_gp-1:0] rs2;
    logic [11:0] imm;
  } instruction_s;

  typedef struct packed {
    logic op_reads_rf1;
    logic op_reads_rf2;
    // Never set for an x0 destination
    logic op_writes_rf;
    logic is_mul_op;
    logic is_imm_op;
    opcode_e alu_op;
  } decode_s;

endpackage

`default_nettype wire

/* hdl/core_pipe_pkg.sv */
/*
 * Pipeline stage registers for ID, EXE and writeback
 */
`default_nettype none

package core_pipe_pkg;

  // Operand fields are sized for the widest supported core
  localparam int data_width_max_gp = 32;

  typedef struct packed {
    logic valid;
    core_isa_pkg::instruction_s instruction;
    core_isa_pkg::decode_s decode;
  } id_signals_s;

  typedef struct packed {
    logic valid;
    logic [core_isa_pkg::reg_addr_width_gp-1:0] rd;
    core_isa_pkg::decode_s decode;
    logic [data_width_max_gp-1:0] rs1_val;
    logic [data_width_max_gp-1:0] rs2_val;
  } exe_signals_s;

  typedef struct packed {
    logic [core_isa_pkg::reg_addr_width_gp-1:0] rd;
    logic [data_width_max_gp-1:0] data;
  } wb_signals_s;

endpackage

`default_nettype wire

/* hdl/instr_decode.sv */
/*
 * Instruction decoder: control flags and sign-extended immediate
 */
`timescale 1ns/1ps
`default_nettype none

module instr_decode #(
  parameter int data_width_p = 32
) (
  input  core_isa_pkg::instruction_s instruction_i,
  output core_isa_pkg::decode_s decode_o,
  output logic [data_width_p-1:0] imm_o
);

  always_comb begin
    decode_o = '0;
    decode_o.alu_op = core_isa_pkg::op_add;
    case (instruction_i.opcode)
      core_isa_pkg::op_add, core_isa_pkg::op_sub, core_isa_pkg::op_and,
      core_isa_pkg::op_or, core_isa_pkg::op_xor, core_isa_pkg::op_sll,
      core_isa_pkg::op_srl: begin
        decode_o.op_reads_rf1 = 1'b1;
        decode_o.op_reads_rf2 = 1'b1;
        decode_o.op_writes_rf = 1'b1;
        decode_o.alu_op = core_isa_pkg::opcode_e'(instruction_i.opcode);
      end
      core_isa_pkg::op_addi: begin
        decode_o.op_reads_rf1 = 1'b1;
        decode_o.op_writes_rf = 1'b1;
        decode_o.is_imm_op = 1'b1;
        decode_o.alu_op = core_isa_pkg::op_addi;
      end
      core_isa_pkg::op_mul: begin
        decode_o.op_reads_rf1 = 1'b1;
        decode_o.op_reads_rf2 = 1'b1;
        decode_o.op_writes_rf = 1'b1;
        decode_o.is_mul_op = 1'b1;
      end
      default: ;
    endcase
    // Result to x0 is dropped, so nothing is written or multiplied
    if (instruction_i.rd == '0) begin
      decode_o.op_writes_rf = 1'b0;
      decode_o.is_mul_op = 1'b0;
    end
  end

  assign imm_o = data_width_p'($signed(instruction_i.imm));

endmodule

`default_nettype wire

/* hdl/regfile.sv */
/*
 * Integer register file, 2 read ports and 1 write port, x0 reads zero
 */
`timescale 1ns/1ps
`default_nettype none

module regfile #(
  parameter int data_width_p = 32,
  localparam int addr_width_lp = core_isa_pkg::reg_addr_width_gp
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic w_v_i,
  input  logic [addr_width_lp-1:0] w_addr_i,
  input  logic [data_width_p-1:0] w_data_i,
  input  logic [addr_width_lp-1:0] r0_addr_i,
  input  logic [addr_width_lp-1:0] r1_addr_i,
  output logic [data_width_p-1:0] r0_data_o,
  output logic [data_width_p-1:0] r1_data_o
);

  logic [data_width_p-1:0] mem_r [core_isa_pkg::reg_els_gp];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < core_isa_pkg::reg_els_gp; i++) begin
        mem_r[i] <= '0;
      end
    end else if (w_v_i) begin
      mem_r[w_addr_i] <= w_data_i;
    end
  end

  // Write-through so a reader in the clearing cycle sees the new value
  assign r0_data_o = (r0_addr_i == '0) ? '0
                   : (w_v_i && w_addr_i == r0_addr_i) ? w_data_i : mem_r[r0_addr_i];
  assign r1_data_o = (r1_addr_i == '0) ? '0
                   : (w_v_i && w_addr_i == r1_addr_i) ? w_data_i : mem_r[r1_addr_i];

  // Writeback never targets x0
  assert property (@(posedge clk_i) disable iff (!rst_n_i) w_v_i |-> w_addr_i != '0);

endmodule

`default_nettype wire

/* hdl/scoreboard.sv */
/*
 * Pending-write scoreboard with RAW and WAW dependency check
 */
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic [core_isa_pkg::reg_addr_width_gp-1:0] src1_id_i,
  input  logic [core_isa_pkg::reg_addr_width_gp-1:0] src2_id_i,
  input  logic [core_isa_pkg::reg_addr_width_gp-1:0] dest_id_i,
  input  logic op_reads_rf1_i,
  input  logic op_reads_rf2_i,
  input  logic op_writes_rf_i,
  input  logic score_i,
  input  logic [core_isa_pkg::reg_addr_width_gp-1:0] score_id_i,
  input  logic clear_i,
  input  logic [core_isa_pkg::reg_addr_width_gp-1:0] clear_id_i,
  output logic dependency_o
);

  localparam int els_lp = core_isa_pkg::reg_els_gp;

  logic [els_lp-1:0] pending_r;
  logic [els_lp-1:0] clear_mask;
  logic [els_lp-1:0] score_mask;
  logic [els_lp-1:0] busy;

  assign clear_mask = {{(els_lp-1){1'b0}}, clear_i} << clear_id_i;
  assign score_mask = {{(els_lp-1){1'b0}}, score_i} << score_id_i;

  // Register cleared this cycle counts as free
  assign busy = pending_r & ~clear_mask;

  assign dependency_o = (op_reads_rf1_i & busy[src1_id_i])
                      | (op_reads_rf2_i & busy[src2_id_i])
                      | (op_writes_rf_i & busy[dest_id_i]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_r <= '0;
    end else begin
      pending_r <= busy | score_mask;
    end
  end

  // Every writeback matches an earlier issue, and issue never doubles up a write
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    clear_i |-> pending_r[clear_id_i]);
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    score_i |-> !busy[score_id_i]);

endmodule

`default_nettype wire

/* hdl/alu.sv */
/*
 * Single-cycle ALU: add, sub, logic ops and logical shifts
 */
`timescale 1ns/1ps
`default_nettype none

module alu #(
  parameter int data_width_p = 32
) (
  input  logic [data_width_p-1:0] a_i,
  input  logic [data_width_p-1:0] b_i,
  input  core_isa_pkg::opcode_e op_i,
  output logic [data_width_p-1:0] result_o
);

  always_comb begin
    case (op_i)
      core_isa_pkg::op_add,
      core_isa_pkg::op_addi: result_o = a_i + b_i;
      core_isa_pkg::op_sub:  result_o = a_i - b_i;
      core_isa_pkg::op_and:  result_o = a_i & b_i;
      core_isa_pkg::op_or:   result_o = a_i | b_i;
      core_isa_pkg::op_xor:  result_o = a_i ^ b_i;
      // shift amount from low 5 bits only
      core_isa_pkg::op_sll:  result_o = a_i << b_i[4:0];
      core_isa_pkg::op_srl:  result_o = a_i >> b_i[4:0];
      default:               result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/imul_iterative.sv */
/*
 * Iterative shift-add multiplier, result held until taken
 */
`timescale 1ns/1ps
`default_nettype none

module imul_iterative #(
  parameter int data_width_p = 32,
  localparam int reg_addr_width_lp = core_isa_pkg::reg_addr_width_gp,
  localparam int cnt_width_lp = $clog2(data_width_p)
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic v_i,
  input  logic [data_width_p-1:0] a_i,
  input  logic [data_width_p-1:0] b_i,
  input  logic [reg_addr_width_lp-1:0] rd_i,
  input  logic yumi_i,
  output logic ready_o,
  output logic v_o,
  output logic [data_width_p-1:0] result_o,
  output logic [reg_addr_width_lp-1:0] rd_o
);

  typedef enum logic [1:0] {
    idle,
    busy,
    done
  } state_e;

  state_e state_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic [data_width_p-1:0] a_r;
  logic [data_width_p-1:0] b_r;
  logic [data_width_p-1:0] acc_r;
  logic [reg_addr_width_lp-1:0] rd_r;
  logic last_step;

  assign last_step = (cnt_r == cnt_width_lp'(data_width_p - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= idle;
    end else begin
      case (state_r)
        idle: if (v_i) begin
          state_r <= busy;
        end
        busy: if (last_step) begin
          state_r <= done;
        end
        done: if (yumi_i) begin
          state_r <= idle;
        end
        default: state_r <= idle;
      endcase
    end
  end

  // One partial product per cycle, low half of the product kept
  always_ff @(posedge clk_i) begin
    if (ready_o && v_i) begin
      a_r <= a_i;
      b_r <= b_i;
      acc_r <= '0;
      cnt_r <= '0;
      rd_r <= rd_i;
    end else if (state_r == busy) begin
      if (b_r[0]) begin
        acc_r <= acc_r + a_r;
      end
      a_r <= a_r << 1;
      b_r <= b_r >> 1;
      cnt_r <= cnt_r + 1'b1;
    end
  end

  assign ready_o = (state_r == idle);
  assign v_o = (state_r == done);
  assign result_o = acc_r;
  assign rd_o = rd_r;

  // Issue logic must not start a second multiply
  assert property (@(posedge clk_i) disable iff (!rst_n_i) v_i |-> ready_o);

endmodule

`default_nettype wire

/* hdl/core_ctrl.sv */
/*
 * ID and EXE stage registers, issue and stall control,
 * writeback selection between ALU and multiplier
 */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl #(
  parameter int data_width_p = 32,
  localparam int reg_addr_width_lp = core_isa_pkg::reg_addr_width_gp
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic instr_v_i,
  input  core_isa_pkg::instruction_s instr_i,
  output logic instr_ready_o,
  output logic wb_v_o,
  output core_pipe_pkg::wb_signals_s wb_o,
  output logic rf_w_v_o,
  output logic [reg_addr_width_lp-1:0] rf_w_addr_o,
  output logic [data_width_p-1:0] rf_w_data_o,
  output logic [reg_addr_width_lp-1:0] rf_r0_addr_o,
  output logic [reg_addr_width_lp-1:0] rf_r1_addr_o,
  input  logic [data_width_p-1:0] rf_r0_data_i,
  input  logic [data_width_p-1:0] rf_r1_data_i,
  output logic sb_reads_rf1_o,
  output logic sb_reads_rf2_o,
  output logic sb_writes_rf_o,
  output logic [reg_addr_width_lp-1:0] sb_dest_id_o,
  output logic sb_score_o,
  output logic sb_clear_o,
  output logic [reg_addr_width_lp-1:0] sb_clear_id_o,
  input  logic dependency_i,
  output logic [data_width_p-1:0] alu_a_o,
  output logic [data_width_p-1:0] alu_b_o,
  output core_isa_pkg::opcode_e alu_op_o,
  input  logic [data_width_p-1:0] alu_result_i,
  output logic md_v_o,
  output logic md_yumi_o,
  output logic [data_width_p-1:0] md_a_o,
  output logic [data_width_p-1:0] md_b_o,
  output logic [reg_addr_width_lp-1:0] md_rd_o,
  input  logic md_ready_i,
  input  logic md_v_i,
  input  logic [data_width_p-1:0] md_result_i,
  input  logic [reg_addr_width_lp-1:0] md_rd_i
);

  core_isa_pkg::decode_s decode;
  logic [data_width_p-1:0] imm;
  core_pipe_pkg::id_signals_s id_n;
  core_pipe_pkg::id_signals_s id_r;
  logic [data_width_p-1:0] id_imm_r;
  core_pipe_pkg::exe_signals_s exe_n;
  core_pipe_pkg::exe_signals_s exe_r;
  core_pipe_pkg::wb_signals_s wb_n;
  core_pipe_pkg::wb_signals_s wb_r;
  logic wb_v_r;
  logic md_free;
  logic issue;
  logic alu_wb;

  instr_decode #(
    .data_width_p(data_width_p)
  ) i_decode (
    .instruction_i(instr_i),
    .decode_o(decode),
    .imm_o(imm)
  );

  // ID stage
  assign id_n.valid = instr_v_i;
  assign id_n.instruction = instr_i;
  assign id_n.decode = decode;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      id_r.valid <= 1'b0;
    end else if (instr_ready_o) begin
      id_r <= id_n;
      id_imm_r <= imm;
    end
  end

  assign rf_r0_addr_o = id_r.instruction.rs1;
  assign rf_r1_addr_o = id_r.instruction.rs2;
  assign sb_reads_rf1_o = id_r.decode.op_reads_rf1;
  assign sb_reads_rf2_o = id_r.decode.op_reads_rf2;
  assign sb_writes_rf_o = id_r.decode.op_writes_rf;
  assign sb_dest_id_o = id_r.instruction.rd;

  // A multiply sitting in EXE is about to start the unit
  assign md_free = md_ready_i & ~(exe_r.valid & exe_r.decode.is_mul_op);
  assign issue = id_r.valid & ~dependency_i & (~id_r.decode.is_mul_op | md_free);
  assign instr_ready_o = ~id_r.valid | issue;
  assign sb_score_o = issue & id_r.decode.op_writes_rf;

  // EXE stage
  always_comb begin
    exe_n = '0;
    exe_n.valid = issue;
    exe_n.rd = id_r.instruction.rd;
    exe_n.decode = id_r.decode;
    exe_n.rs1_val[data_width_p-1:0] = rf_r0_data_i;
    exe_n.rs2_val[data_width_p-1:0] = id_r.decode.is_imm_op ? id_imm_r : rf_r1_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exe_r.valid <= 1'b0;
    end else begin
      exe_r <= exe_n;
    end
  end

  assign alu_a_o = exe_r.rs1_val[data_width_p-1:0];
  assign alu_b_o = exe_r.rs2_val[data_width_p-1:0];
  assign alu_op_o = exe_r.decode.alu_op;
  assign md_v_o = exe_r.valid & exe_r.decode.is_mul_op;
  assign md_a_o = exe_r.rs1_val[data_width_p-1:0];
  assign md_b_o = exe_r.rs2_val[data_width_p-1:0];
  assign md_rd_o = exe_r.rd;

  // ALU first, the multiplier waits for a free slot
  assign alu_wb = exe_r.valid & ~exe_r.decode.is_mul_op & exe_r.decode.op_writes_rf;
  assign md_yumi_o = md_v_i & ~alu_wb;

  always_comb begin
    wb_n = '0;
    if (alu_wb) begin
      wb_n.rd = exe_r.rd;
      wb_n.data[data_width_p-1:0] = alu_result_i;
    end else begin
      wb_n.rd = md_rd_i;
      wb_n.data[data_width_p-1:0] = md_result_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_v_r <= 1'b0;
    end else begin
      wb_v_r <= alu_wb | md_yumi_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_wb || md_yumi_o) begin
      wb_r <= wb_n;
    end
  end

  assign wb_v_o = wb_v_r;
  assign wb_o = wb_r;
  assign rf_w_v_o = wb_v_r;
  assign rf_w_addr_o = wb_r.rd;
  assign rf_w_data_o = wb_r.data[data_width_p-1:0];
  assign sb_clear_o = wb_v_r;
  assign sb_clear_id_o = wb_r.rd;

endmodule

`default_nettype wire

/* hdl/int_core.sv */
/*
 * Integer core top: control, register file, scoreboard, ALU, multiplier
 */
`timescale 1ns/1ps
`default_nettype none

module int_core #(
  parameter int data_width_p = 32
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic instr_v_i,
  input  core_isa_pkg::instruction_s instr_i,
  output logic instr_ready_o,
  output logic wb_v_o,
  output core_pipe_pkg::wb_signals_s wb_o
);

  localparam int reg_addr_width_lp = core_isa_pkg::reg_addr_width_gp;

  // Register file
  logic rf_w_v;
  logic [reg_addr_width_lp-1:0] rf_w_addr;
  logic [data_width_p-1:0] rf_w_data;
  logic [reg_addr_width_lp-1:0] rf_r0_addr;
  logic [reg_addr_width_lp-1:0] rf_r1_addr;
  logic [data_width_p-1:0] rf_r0_data;
  logic [data_width_p-1:0] rf_r1_data;

  // Scoreboard
  logic sb_reads_rf1;
  logic sb_reads_rf2;
  logic sb_writes_rf;
  logic [reg_addr_width_lp-1:0] sb_dest_id;
  logic sb_score;
  logic sb_clear;
  logic [reg_addr_width_lp-1:0] sb_clear_id;
  logic dependency;

  // ALU
  logic [data_width_p-1:0] alu_a;
  logic [data_width_p-1:0] alu_b;
  core_isa_pkg::opcode_e alu_op;
  logic [data_width_p-1:0] alu_result;

  // Multiplier
  logic md_v_li;
  logic md_yumi_li;
  logic [data_width_p-1:0] md_a_li;
  logic [data_width_p-1:0] md_b_li;
  logic [reg_addr_width_lp-1:0] md_rd_li;
  logic md_ready_lo;
  logic md_v_lo;
  logic [data_width_p-1:0] md_result_lo;
  logic [reg_addr_width_lp-1:0] md_rd_lo;

  core_ctrl #(
    .data_width_p(data_width_p)
  ) i_ctrl (
    .clk_i, .rst_n_i,
    .instr_v_i, .instr_i, .instr_ready_o, .wb_v_o, .wb_o,
    .rf_w_v_o(rf_w_v), .rf_w_addr_o(rf_w_addr), .rf_w_data_o(rf_w_data),
    .rf_r0_addr_o(rf_r0_addr), .rf_r1_addr_o(rf_r1_addr),
    .rf_r0_data_i(rf_r0_data), .rf_r1_data_i(rf_r1_data),
    .sb_reads_rf1_o(sb_reads_rf1), .sb_reads_rf2_o(sb_reads_rf2),
    .sb_writes_rf_o(sb_writes_rf), .sb_dest_id_o(sb_dest_id),
    .sb_score_o(sb_score), .sb_clear_o(sb_clear), .sb_clear_id_o(sb_clear_id),
    .dependency_i(dependency),
    .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_op_o(alu_op), .alu_result_i(alu_result),
    .md_v_o(md_v_li), .md_yumi_o(md_yumi_li), .md_a_o(md_a_li), .md_b_o(md_b_li),
    .md_rd_o(md_rd_li), .md_ready_i(md_ready_lo), .md_v_i(md_v_lo),
    .md_result_i(md_result_lo), .md_rd_i(md_rd_lo)
  );

  regfile #(
    .data_width_p(data_width_p)
  ) i_regfile (
    .clk_i, .rst_n_i,
    .w_v_i(rf_w_v), .w_addr_i(rf_w_addr), .w_data_i(rf_w_data),
    .r0_addr_i(rf_r0_addr), .r1_addr_i(rf_r1_addr),
    .r0_data_o(rf_r0_data), .r1_data_o(rf_r1_data)
  );

  // Destination is scored under the same index it is checked against
  scoreboard i_scoreboard (
    .clk_i, .rst_n_i,
    .src1_id_i(rf_r0_addr), .src2_id_i(rf_r1_addr), .dest_id_i(sb_dest_id),
    .op_reads_rf1_i(sb_reads_rf1), .op_reads_rf2_i(sb_reads_rf2),
    .op_writes_rf_i(sb_writes_rf),
    .score_i(sb_score), .score_id_i(sb_dest_id),
    .clear_i(sb_clear), .clear_id_i(sb_clear_id),
    .dependency_o(dependency)
  );

  alu #(
    .data_width_p(data_width_p)
  ) i_alu (
    .a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .result_o(alu_result)
  );

  imul_iterative #(
    .data_width_p(data_width_p)
  ) i_mul (
    .clk_i, .rst_n_i,
    .v_i(md_v_li), .a_i(md_a_li), .b_i(md_b_li), .rd_i(md_rd_li), .yumi_i(md_yumi_li),
    .ready_o(md_ready_lo), .v_o(md_v_lo), .result_o(md_result_lo), .rd_o(md_rd_lo)
  );

endmodule

`default_nettype wire

/* verif/tb_int_core.sv */
/*
 * Testbench for the integer core: stimulus, reference model,
 * writeback checker, watchdog and report
 */
`timescale 1ns/1ps
`default_nettype none

module tb_int_core;

  localparam int data_width_lp = 32;
  localparam int clk_period_lp = 40;
  localparam int n_load_lp = 31;
  localparam int n_alu_lp = 40;
  localparam int n_imm_lp = 20;
  localparam int n_chain_lp = 30;
  localparam int n_mul_lp = 3;
  localparam int n_burst_lp = data_width_lp + 8;
  localparam int n_x0_lp = 8;
  localparam int n_instr_lp = n_load_lp + n_alu_lp + n_imm_lp + n_chain_lp
                            + n_mul_lp * (n_burst_lp + 1) + n_x0_lp;
  localparam int watchdog_cycles_lp = n_instr_lp * (data_width_lp + 4) + 200;

  logic clk;
  logic rst_n;
  logic instr_v;
  core_isa_pkg::instruction_s instr;
  logic instr_ready;
  logic wb_v;
  core_pipe_pkg::wb_signals_s wb;

  logic [31:0] mdl_regs [32];
  core_pipe_pkg::wb_signals_s exp_q [$];
  int check_cnt;
  int err_cnt;
  int gap_max;

  int_core #(
    .data_width_p(data_width_lp)
  ) i_dut (
    .clk_i(clk),
    .rst_n_i(rst_n),
    .instr_v_i(instr_v),
    .instr_i(instr),
    .instr_ready_o(instr_ready),
    .wb_v_o(wb_v),
    .wb_o(wb)
  );

  always #(clk_period_lp / 2) clk = ~clk;

  function automatic core_isa_pkg::instruction_s build_instr(
    input core_isa_pkg::opcode_e op,
    input logic [4:0] rd,
    input logic [4:0] rs1,
    input logic [4:0] rs2,
    input logic [11:0] imm
  );
    core_isa_pkg::instruction_s ins;
    ins.opcode = op;
    ins.rd = rd;
    ins.rs1 = rs1;
    ins.rs2 = rs2;
    ins.imm = imm;
    return ins;
  endfunction

  function automatic core_isa_pkg::opcode_e pick_op(input int sel);
    case (sel)
      0: return core_isa_pkg::op_add;
      1: return core_isa_pkg::op_sub;
      2: return core_isa_pkg::op_and;
      3: return core_isa_pkg::op_or;
      4: return core_isa_pkg::op_xor;
      5: return core_isa_pkg::op_sll;
      6: return core_isa_pkg::op_srl;
      7: return core_isa_pkg::op_addi;
      default: return core_isa_pkg::op_mul;
    endcase
  endfunction

  function automatic logic [4:0] rand_reg(input int lo, input int hi);
    return 5'($urandom_range(hi, lo));
  endfunction

  function automatic bit writes_rd(input core_isa_pkg::instruction_s ins);
    bit known;
    case (ins.opcode)
      core_isa_pkg::op_add, core_isa_pkg::op_sub, core_isa_pkg::op_and,
      core_isa_pkg::op_or, core_isa_pkg::op_xor, core_isa_pkg::op_sll,
      core_isa_pkg::op_srl, core_isa_pkg::op_addi, core_isa_pkg::op_mul: known = 1'b1;
      default: known = 1'b0;
    endcase
    return known && (ins.rd != 5'd0);
  endfunction

  // Reference model of one instruction, 32-bit arithmetic
  function automatic logic [31:0] ref_result(
    input core_isa_pkg::instruction_s ins,
    input logic [31:0] a,
    input logic [31:0] b
  );
    logic [31:0] imm_ext;
    imm_ext = {{20{ins.imm[11]}}, ins.imm};
    case (ins.opcode)
      core_isa_pkg::op_add:  return a + b;
      core_isa_pkg::op_sub:  return a - b;
      core_isa_pkg::op_and:  return a & b;
      core_isa_pkg::op_or:   return a | b;
      core_isa_pkg::op_xor:  return a ^ b;
      core_isa_pkg::op_sll:  return a << b[4:0];
      core_isa_pkg::op_srl:  return a >> b[4:0];
      core_isa_pkg::op_addi: return a + imm_ext;
      core_isa_pkg::op_mul:  return a * b;
      default:               return 32'd0;
    endcase
  endfunction

  // In-order execution on the model at the accepting edge
  task automatic model_accept(input core_isa_pkg::instruction_s ins);
    core_pipe_pkg::wb_signals_s entry;
    logic [31:0] res;
    if (writes_rd(ins)) begin
      res = ref_result(ins, mdl_regs[ins.rs1], mdl_regs[ins.rs2]);
      mdl_regs[ins.rd] = res;
      entry.rd = ins.rd;
      entry.data = res;
      exp_q.push_back(entry);
    end
  endtask

  // Entered and left on a falling edge
  task automatic send_instr(input core_isa_pkg::instruction_s ins);
    int gap;
    gap = $urandom_range(gap_max, 0);
    instr_v = 1'b0;
    repeat (gap) @(negedge clk);
    instr = ins;
    instr_v = 1'b1;
    // Ready only depends on registered state, so it is stable here
    while (!instr_ready) @(negedge clk);
    @(posedge clk);
    model_accept(ins);
    @(negedge clk);
    instr_v = 1'b0;
  endtask

  task automatic finish_test(input string name, input int err_before);
    while (exp_q.size() != 0) @(negedge clk);
    // A few idle cycles to catch a duplicated writeback
    repeat (4) @(negedge clk);
    $display("Test %s finished with %0d errors", name, err_cnt - err_before);
  endtask

  // Writeback checker, sampled mid-cycle
  always @(negedge clk) begin
    int idx;
    if (rst_n && wb_v) begin
      idx = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
        if (idx < 0 && exp_q[i].rd == wb.rd) begin
          idx = i;
        end
      end
      check_cnt++;
      assert (idx >= 0) else begin
        $display("Unexpected writeback to x%0d at time %0t", wb.rd, $time);
        err_cnt++;
      end
      if (idx >= 0) begin
        assert (wb.data == exp_q[idx].data) else begin
          $display("ERR %0t: x%0d written with %h, expected %h",
                   $time, wb.rd, wb.data, exp_q[idx].data);
          err_cnt++;
        end
        exp_q.delete(idx);
      end
    end
  end

  initial begin
    #(watchdog_cycles_lp * clk_period_lp);
    $display("Watchdog expired before all tests finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int err_before;
    void'($urandom(20406));
    clk = 1'b0;
    rst_n = 1'b0;
    instr_v = 1'b0;
    instr = '0;
    check_cnt = 0;
    err_cnt = 0;
    gap_max = 2;
    for (int r = 0; r < 32; r++) begin
      mdl_regs[r] = 32'd0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    err_before = err_cnt;
    check_cnt++;
    assert (wb_v == 1'b0 && instr_ready == 1'b1) else begin
      $display("ERR %0t: after reset wb_v_o=%b instr_ready_o=%b", $time, wb_v, instr_ready);
      err_cnt++;
    end
    finish_test("reset_state", err_before);

    // Sources x1..x15 are loaded once and only read afterwards
    err_before = err_cnt;
    for (int r = 1; r <= n_load_lp; r++) begin
      send_instr(build_instr(core_isa_pkg::op_addi, 5'(r), 5'd0, 5'd0, 12'($urandom)));
    end
    for (int n = 0; n < n_alu_lp; n++) begin
      send_instr(build_instr(pick_op($urandom_range(6, 0)), rand_reg(16, 31),
                             rand_reg(1, 15), rand_reg(1, 15), 12'd0));
    end
    finish_test("alu_random", err_before);

    err_before = err_cnt;
    for (int n = 0; n < n_imm_lp; n++) begin
      send_instr(build_instr(core_isa_pkg::op_addi, rand_reg(1, 31), rand_reg(0, 31),
                             5'd0, 12'h800 | 12'($urandom_range(2047, 0))));
    end
    finish_test("addi_negative", err_before);

    // Few registers, so RAW and WAW hazards are frequent
    err_before = err_cnt;
    for (int n = 0; n < n_chain_lp; n++) begin
      send_instr(build_instr(pick_op($urandom_range(7, 0)), rand_reg(1, 4),
                             rand_reg(1, 4), rand_reg(1, 4), 12'($urandom)));
    end
    finish_test("dependent_chains", err_before);

    // Each product becomes ready inside a gapless ALU burst and has to wait for it
    err_before = err_cnt;
    for (int m = 0; m < n_mul_lp; m++) begin
      send_instr(build_instr(core_isa_pkg::op_mul, rand_reg(1, 7),
                             rand_reg(8, 15), rand_reg(8, 15), 12'd0));
      gap_max = 0;
      for (int n = 0; n < n_burst_lp; n++) begin
        send_instr(build_instr(pick_op($urandom_range(7, 0)), 5'(16 + n % 16),
                               rand_reg(8, 15), rand_reg(8, 15), 12'($urandom)));
      end
      gap_max = 2;
    end
    finish_test("mul_mixed", err_before);

    err_before = err_cnt;
    for (int n = 0; n < n_x0_lp - 2; n++) begin
      send_instr(build_instr(pick_op($urandom_range(8, 0)), 5'd0,
                             rand_reg(1, 31), rand_reg(1, 31), 12'($urandom)));
    end
    send_instr(build_instr(core_isa_pkg::op_add, 5'd20, 5'd0, 5'd0, 12'd0));
    send_instr(build_instr(core_isa_pkg::op_or, 5'd21, 5'd0, 5'd0, 12'd0));
    finish_test("x0_writes", err_before);

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/core_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/instr_decode.sv
hdl/regfile.sv
hdl/scoreboard.sv
hdl/alu.sv
hdl/imul_iterative.sv
hdl/core_ctrl.sv
hdl/int_core.sv
verif/tb_int_core.sv

/* Makefile */
TOP := tb_int_core

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing --assert -f all.f --top-module int_core

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
